// ==== filelist.f ====
rtl/la_pkg.sv
rtl/uart_rx.sv
rtl/cmd_decoder.sv
rtl/capture_ctrl.sv
rtl/trigger_unit.sv
rtl/sample_mem.sv
rtl/reply_encoder.sv
rtl/uart_tx.sv
rtl/la_top.sv
testbench/la_assert.sv
testbench/la_tb.sv

// ==== rtl/capture_ctrl.sv ====
`timescale 1ns/1ps

module capture_ctrl #(
    parameter int SAMPLE_DEPTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  la_pkg::bus_req_t                req_i,
    input  logic                            trig_i,
    output la_pkg::bus_req_t                req_o,
    output logic [$clog2(SAMPLE_DEPTH)-1:0] wr_addr_o,
    output logic                            wr_en_o
);

    import la_pkg::*;

    localparam int AW = $clog2(SAMPLE_DEPTH);

    cap_state_e    state;
    logic [AW-1:0] trigger_loc;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic          request_start;
    logic          request_stop;
    logic          start_q;
    logic          stop_q;

    assign wr_addr_o = wr_ptr;
    // capturing stops writing once the write pointer catches the oldest sample
    assign wr_en_o = (state == MOVE_TO_POSITION) || (state == IN_POSITION) ||
                     (state == CAPTURING && wr_ptr != rd_ptr);

    // register block
    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_o         <= '0;
            trigger_loc   <= '0;
            request_start <= 1'b0;
            request_stop  <= 1'b0;
        end else begin
            req_o <= req_i;
            if (req_i.valid && req_i.rw) begin
                case (req_i.addr)
                    ADDR_TRIG_LOC: trigger_loc   <= req_i.data[AW-1:0];
                    ADDR_START:    request_start <= req_i.data[0];
                    ADDR_STOP:     request_stop  <= req_i.data[0];
                    default:       ;
                endcase
            end else if (req_i.valid) begin
                case (req_i.addr)
                    ADDR_STATE:    req_o.data <= BUS_W'(state);
                    ADDR_TRIG_LOC: req_o.data <= BUS_W'(trigger_loc);
                    ADDR_START:    req_o.data <= BUS_W'(request_start);
                    ADDR_STOP:     req_o.data <= BUS_W'(request_stop);
                    ADDR_RD_PTR:   req_o.data <= BUS_W'(rd_ptr);
                    ADDR_WR_PTR:   req_o.data <= BUS_W'(wr_ptr);
                    default:       ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= IDLE;
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            start_q <= 1'b0;
            stop_q  <= 1'b0;
        end else begin
            start_q <= request_start;
            stop_q  <= request_stop;
            case (state)
                IDLE: begin
                    rd_ptr <= '0;
                    wr_ptr <= '0;
                    if (request_start && !start_q) begin
                        state <= MOVE_TO_POSITION;
                    end
                end
                MOVE_TO_POSITION: begin
                    // fill the pre-trigger part of the buffer
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_ptr == trigger_loc) begin
                        state <= trig_i ? CAPTURING : IN_POSITION;
                    end
                end
                IN_POSITION: begin
                    // rolling window, the oldest sample moves with the newest
                    wr_ptr <= wr_ptr + 1'b1;
                    rd_ptr <= rd_ptr + 1'b1;
                    if (trig_i) begin
                        state <= CAPTURING;
                    end
                end
                CAPTURING: begin
                    if (wr_ptr == rd_ptr) begin
                        state <= CAPTURED;
                    end else begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
                default: ;
            endcase
            // stop wins over everything else
            if (request_stop && !stop_q) begin
                state <= IDLE;
            end
        end
    end

endmodule

// ==== rtl/cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder (
    input  logic             clk,
    input  logic             rst_i,
    input  logic [7:0]       byte_i,
    input  logic             byte_valid_i,
    output la_pkg::bus_req_t req_o
);

    import la_pkg::*;

    typedef enum logic [1:0] {DEC_IDLE, DEC_READ, DEC_WRITE} dec_state_e;

    dec_state_e  state;
    logic [3:0]  byte_cnt;
    logic [3:0]  digits_needed;
    logic [31:0] digits;
    logic        is_term;

    // only uppercase hex is accepted
    function automatic logic is_hex(input logic [7:0] c);
        return (c >= 8'h30 && c <= 8'h39) || (c >= 8'h41 && c <= 8'h46);
    endfunction

    function automatic logic [3:0] hex_val(input logic [7:0] c);
        if (c <= 8'h39) begin
            return c[3:0];
        end
        return c[3:0] + 4'd9;
    endfunction

    assign is_term       = (byte_i == CHAR_CR) || (byte_i == CHAR_LF);
    assign digits_needed = (state == DEC_WRITE) ? 4'd8 : 4'd4;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= DEC_IDLE;
            byte_cnt <= '0;
            req_o    <= '0;
        end else begin
            req_o.valid <= 1'b0;
            if (byte_valid_i) begin
                if (state == DEC_IDLE) begin
                    byte_cnt <= '0;
                    if (byte_i == CHAR_R) begin
                        state <= DEC_READ;
                    end else if (byte_i == CHAR_W) begin
                        state <= DEC_WRITE;
                    end
                end else if (byte_cnt != digits_needed) begin
                    if (is_hex(byte_i)) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end else begin
                        state <= DEC_IDLE;
                    end
                end else begin
                    // all digits in, only a terminator issues the transaction
                    state <= DEC_IDLE;
                    if (is_term) begin
                        req_o.valid <= 1'b1;
                        req_o.rw    <= (state == DEC_WRITE);
                        req_o.addr  <= (state == DEC_WRITE) ? digits[31:16] : digits[15:0];
                        req_o.data  <= (state == DEC_WRITE) ? digits[15:0] : '0;
                    end
                end
            end
        end
    end

    // nibbles shift in, the last four digits land in the low half
    always_ff @(posedge clk) begin
        if (byte_valid_i && state != DEC_IDLE && is_hex(byte_i)) begin
            digits <= {digits[27:0], hex_val(byte_i)};
        end
    end

endmodule

// ==== rtl/la_pkg.sv ====
package la_pkg;

    localparam int BUS_W = 16;

    // one bus transaction, handed from stage to stage
    typedef struct packed {
        logic             valid;
        logic             rw;
        logic [BUS_W-1:0] addr;
        logic [BUS_W-1:0] data;
    } bus_req_t;

    // capture controller registers
    localparam logic [BUS_W-1:0] ADDR_STATE    = 16'd0;
    localparam logic [BUS_W-1:0] ADDR_TRIG_LOC = 16'd1;
    localparam logic [BUS_W-1:0] ADDR_START    = 16'd2;
    localparam logic [BUS_W-1:0] ADDR_STOP     = 16'd3;
    localparam logic [BUS_W-1:0] ADDR_RD_PTR   = 16'd4;
    localparam logic [BUS_W-1:0] ADDR_WR_PTR   = 16'd5;

    // trigger unit registers
    localparam logic [BUS_W-1:0] ADDR_TRIG_OP  = 16'd6;
    localparam logic [BUS_W-1:0] ADDR_TRIG_ARG = 16'd7;

    // sample k sits at ADDR_SAMPLE_BASE + k
    localparam logic [BUS_W-1:0] ADDR_SAMPLE_BASE = 16'd8;

    typedef enum logic [3:0] {
        DISABLE, RISING, FALLING, CHANGING, GT, LT, GEQ, LEQ, EQ, NEQ
    } trig_op_e;

    typedef enum logic [3:0] {
        IDLE             = 4'd0,
        MOVE_TO_POSITION = 4'd1,
        IN_POSITION      = 4'd2,
        CAPTURING        = 4'd3,
        CAPTURED         = 4'd4
    } cap_state_e;

    localparam logic [7:0] CHAR_R  = 8'h52;
    localparam logic [7:0] CHAR_W  = 8'h57;
    localparam logic [7:0] CHAR_D  = 8'h44;
    localparam logic [7:0] CHAR_CR = 8'h0D;
    localparam logic [7:0] CHAR_LF = 8'h0A;

endpackage

// ==== rtl/la_top.sv ====
`timescale 1ns/1ps

module la_top #(
    parameter int CLOCKS_PER_BAUD = 8,
    parameter int SAMPLE_DEPTH    = 32,
    parameter int PROBE_W         = 16
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               rx_i,
    input  logic [PROBE_W-1:0] probe_i,
    output logic               tx_o
);

    import la_pkg::*;

    logic [7:0]                      rx_byte;
    logic                            rx_valid;
    bus_req_t                        dec_req;
    bus_req_t                        cap_req;
    bus_req_t                        trg_req;
    bus_req_t                        mem_req;
    logic                            trig;
    logic [$clog2(SAMPLE_DEPTH)-1:0] wr_addr;
    logic                            wr_en;
    logic [7:0]                      tx_byte;
    logic                            tx_start;
    logic                            tx_done;

    uart_rx #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) u_uart_rx (
        .clk(clk), .rst_i(rst_i), .rx_i(rx_i),
        .byte_o(rx_byte), .byte_valid_o(rx_valid)
    );

    cmd_decoder u_cmd_decoder (
        .clk(clk), .rst_i(rst_i), .byte_i(rx_byte), .byte_valid_i(rx_valid),
        .req_o(dec_req)
    );

    capture_ctrl #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_capture_ctrl (
        .clk(clk), .rst_i(rst_i), .req_i(dec_req), .trig_i(trig),
        .req_o(cap_req), .wr_addr_o(wr_addr), .wr_en_o(wr_en)
    );

    trigger_unit #(.PROBE_W(PROBE_W)) u_trigger_unit (
        .clk(clk), .rst_i(rst_i), .req_i(cap_req), .probe_i(probe_i),
        .req_o(trg_req), .trig_o(trig)
    );

    sample_mem #(.SAMPLE_DEPTH(SAMPLE_DEPTH), .PROBE_W(PROBE_W)) u_sample_mem (
        .clk(clk), .rst_i(rst_i), .req_i(trg_req), .probe_i(probe_i),
        .wr_addr_i(wr_addr), .wr_en_i(wr_en), .req_o(mem_req)
    );

    reply_encoder u_reply_encoder (
        .clk(clk), .rst_i(rst_i), .req_i(mem_req), .done_i(tx_done),
        .byte_o(tx_byte), .start_o(tx_start)
    );

    uart_tx #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) u_uart_tx (
        .clk(clk), .rst_i(rst_i), .byte_i(tx_byte), .start_i(tx_start),
        .done_o(tx_done), .tx_o(tx_o)
    );

endmodule

// ==== rtl/reply_encoder.sv ====
`timescale 1ns/1ps

module reply_encoder (
    input  logic             clk,
    input  logic             rst_i,
    input  la_pkg::bus_req_t req_i,
    input  logic             done_i,
    output logic [7:0]       byte_o,
    output logic             start_o
);

    import la_pkg::*;

    localparam logic [2:0] LAST_BYTE = 3'd6;

    logic             busy;
    logic [2:0]       byte_cnt;
    logic [BUS_W-1:0] word;
    logic             last_ack;
    logic             take;

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? (8'h30 + 8'(n)) : (8'h37 + 8'(n));
    endfunction

    assign start_o  = busy;
    assign last_ack = busy && done_i && (byte_cnt == LAST_BYTE);
    // a new read is only picked up when the encoder is free
    assign take     = req_i.valid && !req_i.rw && (!busy || last_ack);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy     <= 1'b0;
            byte_cnt <= '0;
        end else begin
            if (busy && done_i) begin
                byte_cnt <= last_ack ? 3'd0 : byte_cnt + 1'b1;
            end
            if (take) begin
                busy <= 1'b1;
            end else if (last_ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            word <= req_i.data;
        end
    end

    always_comb begin
        case (byte_cnt)
            3'd0:    byte_o = CHAR_D;
            3'd1:    byte_o = hex_char(word[15:12]);
            3'd2:    byte_o = hex_char(word[11:8]);
            3'd3:    byte_o = hex_char(word[7:4]);
            3'd4:    byte_o = hex_char(word[3:0]);
            3'd5:    byte_o = CHAR_CR;
            default: byte_o = CHAR_LF;
        endcase
    end

endmodule

// ==== rtl/sample_mem.sv ====
`timescale 1ns/1ps

module sample_mem #(
    parameter int SAMPLE_DEPTH = 32,
    parameter int PROBE_W      = 16
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  la_pkg::bus_req_t                req_i,
    input  logic [PROBE_W-1:0]              probe_i,
    input  logic [$clog2(SAMPLE_DEPTH)-1:0] wr_addr_i,
    input  logic                            wr_en_i,
    output la_pkg::bus_req_t                req_o
);

    import la_pkg::*;

    localparam int AW = $clog2(SAMPLE_DEPTH);

    logic [PROBE_W-1:0] mem [SAMPLE_DEPTH];
    logic [PROBE_W-1:0] rd_q;
    logic [BUS_W-1:0]   offset;
    logic               hit;
    logic               hit_q;
    bus_req_t           pipe_q;

    assign offset = req_i.addr - ADDR_SAMPLE_BASE;
    assign hit    = req_i.valid && !req_i.rw && req_i.addr >= ADDR_SAMPLE_BASE &&
                    offset < SAMPLE_DEPTH;

    // capture writes on one side, bus reads on the other
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= probe_i;
        end
        rd_q <= mem[offset[AW-1:0]];
    end

    // the transaction waits beside the read so the data lines up
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pipe_q <= '0;
            hit_q  <= 1'b0;
            req_o  <= '0;
        end else begin
            pipe_q <= req_i;
            hit_q  <= hit;
            req_o  <= pipe_q;
            if (hit_q) begin
                req_o.data <= BUS_W'(rd_q);
            end
        end
    end

endmodule

// ==== rtl/trigger_unit.sv ====
`timescale 1ns/1ps

module trigger_unit #(
    parameter int PROBE_W = 16
) (
    input  logic               clk,
    input  logic               rst_i,
    input  la_pkg::bus_req_t   req_i,
    input  logic [PROBE_W-1:0] probe_i,
    output la_pkg::bus_req_t   req_o,
    output logic               trig_o
);

    import la_pkg::*;

    trig_op_e           op;
    logic [PROBE_W-1:0] arg;
    logic [PROBE_W-1:0] probe_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_o   <= '0;
            op      <= DISABLE;
            arg     <= '0;
            probe_q <= '0;
        end else begin
            req_o   <= req_i;
            probe_q <= probe_i;
            if (req_i.valid && req_i.rw) begin
                case (req_i.addr)
                    ADDR_TRIG_OP:  op  <= trig_op_e'(req_i.data[3:0]);
                    ADDR_TRIG_ARG: arg <= req_i.data[PROBE_W-1:0];
                    default:       ;
                endcase
            end else if (req_i.valid) begin
                case (req_i.addr)
                    ADDR_TRIG_OP:  req_o.data <= BUS_W'(op);
                    ADDR_TRIG_ARG: req_o.data <= BUS_W'(arg);
                    default:       ;
                endcase
            end
        end
    end

    // edge ops look at the previous probe, relational ops at arg
    always_comb begin
        case (op)
            RISING:   trig_o = (probe_i > probe_q);
            FALLING:  trig_o = (probe_i < probe_q);
            CHANGING: trig_o = (probe_i != probe_q);
            GT:       trig_o = (probe_i > arg);
            LT:       trig_o = (probe_i < arg);
            GEQ:      trig_o = (probe_i >= arg);
            LEQ:      trig_o = (probe_i <= arg);
            EQ:       trig_o = (probe_i == arg);
            NEQ:      trig_o = (probe_i != arg);
            default:  trig_o = 1'b0;
        endcase
    end

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLOCKS_PER_BAUD = 8
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       rx_i,
    output logic [7:0] byte_o,
    output logic       byte_valid_o
);

    localparam int CNT_W = $clog2(2 * CLOCKS_PER_BAUD);
    localparam logic [3:0] BIT_STOP = 4'd9;

    logic             rx_meta;
    logic             rx_sync;
    logic [3:0]       bit_state;
    logic [CNT_W-1:0] baud_cnt;
    logic             baud_zero;

    assign baud_zero = (baud_cnt == '0);

    // line idles high, so the synchronizer resets to one
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    // bit_state 0 is idle, 1..8 are data bits, 9 is the stop bit
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bit_state    <= '0;
            baud_cnt     <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            if (bit_state == 4'd0) begin
                // start edge, wait until the middle of bit 0
                if (!rx_sync) begin
                    bit_state <= 4'd1;
                    baud_cnt  <= CNT_W'(CLOCKS_PER_BAUD + CLOCKS_PER_BAUD / 2 - 1);
                end
            end else if (baud_zero) begin
                if (bit_state == BIT_STOP) begin
                    bit_state    <= 4'd0;
                    byte_valid_o <= 1'b1;
                end else begin
                    bit_state <= bit_state + 1'b1;
                    baud_cnt  <= CNT_W'(CLOCKS_PER_BAUD - 1);
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (baud_zero && bit_state != 4'd0 && bit_state != BIT_STOP) begin
            byte_o <= {rx_sync, byte_o[7:1]};
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLOCKS_PER_BAUD = 8
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic [7:0] byte_i,
    input  logic       start_i,
    output logic       done_o,
    output logic       tx_o
);

    localparam int CNT_W = $clog2(CLOCKS_PER_BAUD);

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;
    logic [8:0]       frame;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_o     <= 1'b1;
            done_o   <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (start_i && done_o) begin
            // start bit goes out straight away
            tx_o     <= 1'b0;
            done_o   <= 1'b0;
            baud_cnt <= CNT_W'(CLOCKS_PER_BAUD - 1);
            bit_idx  <= '0;
        end else if (!done_o) begin
            baud_cnt <= baud_cnt - 1'b1;
            // done rises in the last cycle of the stop bit, so a held start chains
            done_o   <= (baud_cnt == CNT_W'(1)) && (bit_idx == 4'd9);
            if (baud_cnt == '0) begin
                baud_cnt <= CNT_W'(CLOCKS_PER_BAUD - 1);
                tx_o     <= frame[bit_idx];
                bit_idx  <= bit_idx + 1'b1;
            end
        end
    end

    // data bits then the stop bit
    always_ff @(posedge clk) begin
        if (start_i && done_o) begin
            frame <= {1'b1, byte_i};
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the logic analyzer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module la_tb -f filelist.f -o la_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/la_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== testbench/la_assert.sv ====
`timescale 1ns/1ps

module la_assert (
    input logic             clk,
    input logic             rst_i,
    input la_pkg::bus_req_t req_i,
    input logic [3:0]       state_i,
    input logic             wr_en_i
);

    import la_pkg::*;

    // a whole command line separates two decoder transactions
    a_single_valid: assert property (@(posedge clk) disable iff (rst_i)
        req_i.valid |=> !req_i.valid)
        else $error("decoder issued valid on two consecutive cycles");

    a_legal_state: assert property (@(posedge clk) disable iff (rst_i)
        state_i <= 4'(CAPTURED))
        else $error("capture state outside the legal range");

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst_i)
        (state_i == 4'(IDLE)) |-> !wr_en_i)
        else $error("sample write enabled while idle");

endmodule

bind capture_ctrl la_assert u_la_assert (
    .clk(clk),
    .rst_i(rst_i),
    .req_i(req_i),
    .state_i(state),
    .wr_en_i(wr_en_o)
);

// ==== testbench/la_tb.sv ====
`timescale 1ns/1ps

module la_tb;

    import la_pkg::*;

    localparam int CLOCKS_PER_BAUD = 8;
    localparam int SAMPLE_DEPTH    = 32;
    localparam int PROBE_W         = 16;
    localparam int BYTE_TIMEOUT    = 4000;
    localparam int QUIET_CYCLES    = 300;
    localparam int MAX_POLLS       = 20;

    logic               clk;
    logic               rst_i;
    logic               rx_i;
    logic [PROBE_W-1:0] probe;
    logic               tx_o;

    int          seed = 57252;
    logic [15:0] model_regs [8];

    la_top #(
        .CLOCKS_PER_BAUD(CLOCKS_PER_BAUD),
        .SAMPLE_DEPTH(SAMPLE_DEPTH),
        .PROBE_W(PROBE_W)
    ) DUT (
        .clk(clk), .rst_i(rst_i), .rx_i(rx_i), .probe_i(probe), .tx_o(tx_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // counting probe, one step per clock
    always @(posedge clk) begin
        probe <= probe + 1'b1;
    end

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};
        end
        return 8'h41 + {4'h0, n} - 8'd10;
    endfunction

    // unknown characters decode as zero and then fail the text compare
    function automatic logic [3:0] hex_value(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) begin
            return 4'(c - 8'h30);
        end
        if (c >= 8'h41 && c <= 8'h46) begin
            return 4'(c - 8'h41 + 8'd10);
        end
        return 4'h0;
    endfunction

    // expected reply text for a read word, one character per index
    function automatic logic [7:0] reply_char(input logic [15:0] word, input int idx);
        case (idx)
            0:          return CHAR_D;
            1, 2, 3, 4: return hex_char(word[4*(4-idx) +: 4]);
            5:          return CHAR_CR;
            default:    return CHAR_LF;
        endcase
    endfunction

    function automatic logic is_writable(input logic [15:0] addr);
        return addr == ADDR_TRIG_LOC || addr == ADDR_START || addr == ADDR_STOP ||
               addr == ADDR_TRIG_OP || addr == ADDR_TRIG_ARG;
    endfunction

    function automatic logic [15:0] reg_mask(input logic [15:0] addr, input logic [15:0] data);
        case (addr)
            ADDR_TRIG_LOC:         return data & 16'(SAMPLE_DEPTH - 1);
            ADDR_START, ADDR_STOP: return data & 16'h0001;
            ADDR_TRIG_OP:          return data & 16'h000F;
            default:               return data & 16'((1 << PROBE_W) - 1);
        endcase
    endfunction

    // register map model, everything past the register block reads zero
    function automatic logic [15:0] ref_read(input logic [15:0] addr);
        if (addr < ADDR_SAMPLE_BASE) begin
            return model_regs[addr[2:0]];
        end
        return 16'h0000;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected 0x%04h actual 0x%04h",
                                name, expected, actual));
        end
    endtask

    // 8N1 frame on rx_i, each bit held for one baud period
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (CLOCKS_PER_BAUD - 1) @(posedge clk);
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    task automatic send_hex4(input logic [15:0] v);
        for (int i = 3; i >= 0; i--) begin
            send_byte(hex_char(v[4*i +: 4]));
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
        send_byte(CHAR_W);
        send_hex4(addr);
        send_hex4(data);
        send_byte(CHAR_LF);
        if (is_writable(addr)) begin
            model_regs[addr[2:0]] = reg_mask(addr, data);
        end
    endtask

    // sampled at the falling edge, in the middle of each bit
    task automatic receive_byte(output logic [7:0] b);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        while (tx_o !== 1'b0 && wait_cnt < BYTE_TIMEOUT) begin
            wait_cnt++;
            @(negedge clk);
        end
        if (wait_cnt == BYTE_TIMEOUT) begin
            abort_run("timed out waiting for a start bit on tx_o");
        end
        repeat (CLOCKS_PER_BAUD / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (CLOCKS_PER_BAUD) @(negedge clk);
            b[i] = tx_o;
        end
        repeat (CLOCKS_PER_BAUD) @(negedge clk);
        if (tx_o !== 1'b1) begin
            abort_run("stop bit on tx_o was not high");
        end
    endtask

    task automatic expect_silence(input string name);
        int quiet;
        quiet = 0;
        @(negedge clk);
        while (tx_o === 1'b1 && quiet < QUIET_CYCLES) begin
            quiet++;
            @(negedge clk);
        end
        if (quiet < QUIET_CYCLES) begin
            abort_run($sformatf("%s produced a reply on tx_o", name));
        end
    endtask

    task automatic read_word(input logic [15:0] addr, output logic [15:0] word);
        logic [7:0] reply [7];
        send_byte(CHAR_R);
        send_hex4(addr);
        send_byte(CHAR_CR);
        for (int i = 0; i < 7; i++) begin
            receive_byte(reply[i]);
        end
        word = '0;
        for (int i = 1; i <= 4; i++) begin
            word = {word[11:0], hex_value(reply[i])};
        end
        for (int i = 0; i < 7; i++) begin
            compare("reply text", reply_char(word, i), reply[i]);
        end
    endtask

    task automatic expect_read(input logic [15:0] addr, input string name);
        logic [15:0] word;
        read_word(addr, word);
        compare(name, ref_read(addr), word);
    endtask

    task automatic wait_captured(input string name);
        logic [15:0] cap_state;
        int          polls;
        polls = 0;
        read_word(ADDR_STATE, cap_state);
        while (cap_state != 16'(CAPTURED) && polls < MAX_POLLS) begin
            polls++;
            read_word(ADDR_STATE, cap_state);
        end
        if (cap_state != 16'(CAPTURED)) begin
            abort_run($sformatf("%s never reached the captured state", name));
        end
    endtask

    task automatic check_window(input logic [15:0] arg);
        logic [15:0] rd_ptr;
        logic [15:0] wr_ptr;
        logic [15:0] sample;
        logic [15:0] prev;
        logic        seen;
        seen = 1'b0;
        prev = '0;
        read_word(ADDR_RD_PTR, rd_ptr);
        read_word(ADDR_WR_PTR, wr_ptr);
        compare("pointers meet", rd_ptr, wr_ptr);
        // oldest sample first, wrapping around the buffer
        for (int i = 0; i < SAMPLE_DEPTH; i++) begin
            read_word(ADDR_SAMPLE_BASE + ((rd_ptr + 16'(i)) & 16'(SAMPLE_DEPTH - 1)), sample);
            if (i > 0) begin
                compare("sample step", prev + 16'd1, sample);
            end
            seen = seen | (sample == arg);
            prev = sample;
        end
        compare("trigger arg captured", 16'd1, 16'(seen));
    endtask

    initial begin
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] arg;
        logic [15:0] sel;
        rst_i = 1'b1;
        rx_i  = 1'b1;
        probe = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        repeat (4) @(posedge clk);

        // reset state and reply format
        expect_read(ADDR_STATE, "state after reset");

        // random register traffic
        for (int n = 0; n < 8; n++) begin
            sel  = 16'($unsigned($random(seed)) % 3);
            addr = (sel == 0) ? ADDR_TRIG_LOC : (sel == 1) ? ADDR_TRIG_OP : ADDR_TRIG_ARG;
            data = 16'($random(seed));
            write_reg(addr, data);
            expect_read(addr, "register readback");
        end
        addr = 16'h0100 | 16'($unsigned($random(seed)) % 256);
        expect_read(addr, "unmapped address");

        // malformed lines give no reply
        send_text("R000a");
        send_byte(CHAR_CR);
        expect_silence("lowercase digit");
        send_text("R0001R");
        expect_silence("missing terminator");
        send_text("Q0000");
        send_byte(CHAR_CR);
        expect_silence("unknown command letter");
        expect_read(ADDR_TRIG_OP, "read after malformed lines");

        // EQ capture, arg far enough ahead that the pre-trigger fill ends first
        write_reg(ADDR_TRIG_LOC, 16'd8);
        write_reg(ADDR_TRIG_OP, 16'(EQ));
        arg = probe + 16'd3000;
        write_reg(ADDR_TRIG_ARG, arg);
        write_reg(ADDR_START, 16'd1);
        wait_captured("EQ capture");
        check_window(arg);

        // stop, then a second capture on the rising probe
        write_reg(ADDR_STOP, 16'd1);
        expect_read(ADDR_STATE, "state after stop");
        expect_read(ADDR_WR_PTR, "write pointer after stop");
        write_reg(ADDR_TRIG_OP, 16'(RISING));
        write_reg(ADDR_START, 16'd0);
        write_reg(ADDR_START, 16'd1);
        wait_captured("RISING capture");
        read_word(ADDR_RD_PTR, addr);
        read_word(ADDR_WR_PTR, data);
        compare("pointers meet after second capture", addr, data);

        $display(">>> PASS");
        $finish;
    end

endmodule
